/* rtl/systolic_pkg.sv */
`default_nettype none

package systolic_pkg;

    // spike activation format
    // four time steps per row, each a 2-bit unsigned count (0..3)
    localparam int TIME_STEPS  = 4;
    localparam int SPIKE_WIDTH = 2;

    // signed weight and per-lane partial sum widths
    localparam int WEIGHT_WIDTH = 8;
    localparam int LANE_WIDTH   = 16;

    // row index carried in a weight write, up to 16 rows
    localparam int ROW_IDX_WIDTH = 4;

    // ping-pong weight bank select
    typedef enum logic {
        BANK0 = 1'b0,
        BANK1 = 1'b1
    } bank_e;

    // one activation beat as seen by a single PE
    typedef struct packed {
        logic                                   valid;
        bank_e                                  bank;
        logic [TIME_STEPS-1:0][SPIKE_WIDTH-1:0] spikes;
    } spike_beat_t;

    // partial sums flowing down the column, lanes are two's complement
    typedef struct packed {
        logic                                  valid;
        logic [TIME_STEPS-1:0][LANE_WIDTH-1:0] lanes;
    } psum_beat_t;

    // weight write request from outside
    typedef struct packed {
        logic                           valid;
        bank_e                          bank;
        logic [ROW_IDX_WIDTH-1:0]       row;
        logic signed [WEIGHT_WIDTH-1:0] value;
    } weight_wr_t;

    // multi-pass accumulator FSM
    typedef enum logic {
        ACC_IDLE = 1'b0,
        ACC_RUN  = 1'b1
    } accum_state_e;

endpackage

`default_nettype wire

/* rtl/weight_loader.sv */
`default_nettype none

module weight_loader #(
    parameter int NUM_ROWS = 8
) (
    input  logic                                       s_clk,
    input  logic                                       s_rst,
    input  systolic_pkg::weight_wr_t                   wr,
    output logic [NUM_ROWS-1:0]                        row_we,
    output systolic_pkg::bank_e                        wr_bank,
    output logic signed [systolic_pkg::WEIGHT_WIDTH-1:0] wr_value
);
    import systolic_pkg::*;

    logic [NUM_ROWS-1:0] row_dec;

    // one-hot decode over the rows that exist
    // an index of NUM_ROWS or above matches nothing and the write is lost
    always_comb begin
        row_dec = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (wr.row == ROW_IDX_WIDTH'(r)) begin
                row_dec[r] = 1'b1;
            end
        end
    end

    // strobes are single-cycle
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            row_we <= '0;
        end else begin
            row_we <= wr.valid ? row_dec : '0;
        end
    end

    // bank and value only matter while a strobe is high
    always_ff @(posedge s_clk) begin
        if (wr.valid) begin
            wr_bank  <= wr.bank;
            wr_value <= wr.value;
        end
    end

endmodule

`default_nettype wire

/* rtl/spike_skew_feeder.sv */
`default_nettype none

module spike_skew_feeder #(
    parameter int NUM_ROWS = 8
) (
    input  logic                                          s_clk,
    input  logic                                          s_rst,
    input  logic                                          act_valid,
    input  systolic_pkg::bank_e                           act_bank,
    input  logic                                          act_first,
    input  logic                                          act_last,
    input  logic [NUM_ROWS-1:0]
                 [systolic_pkg::TIME_STEPS*systolic_pkg::SPIKE_WIDTH-1:0] act_spikes,
    output systolic_pkg::spike_beat_t [NUM_ROWS-1:0]     row_beat,
    output logic                                          pass_first,
    output logic                                          pass_last
);
    import systolic_pkg::*;

    // markers must cover the skew of the last row plus the two PE stages
    localparam int MARK_DEPTH = NUM_ROWS + 1;

    spike_beat_t [NUM_ROWS-1:0] in_q;
    logic [MARK_DEPTH:0]        first_q;
    logic [MARK_DEPTH:0]        last_q;

    // input register, bank travels with each row
    // marker bit 0 is captured together with the vector
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            in_q    <= '0;
            first_q <= '0;
            last_q  <= '0;
        end else begin
            for (int k = 0; k < NUM_ROWS; k++) begin
                in_q[k].valid  <= act_valid;
                in_q[k].bank   <= act_bank;
                in_q[k].spikes <= act_spikes[k];
            end
            first_q <= {first_q[MARK_DEPTH-1:0], act_valid & act_first};
            last_q  <= {last_q[MARK_DEPTH-1:0], act_valid & act_last};
        end
    end

    assign pass_first = first_q[MARK_DEPTH];
    assign pass_last  = last_q[MARK_DEPTH];

    // triangular skew, row k gets k extra stages
    genvar k;
    generate
        for (k = 0; k < NUM_ROWS; k++) begin : g_row
            if (k == 0) begin : g_direct
                assign row_beat[0] = in_q[0];
            end else begin : g_delay
                spike_beat_t [k-1:0] dly_q;

                always_ff @(posedge s_clk or posedge s_rst) begin
                    if (s_rst) begin
                        dly_q <= '0;
                    end else begin
                        dly_q[0] <= in_q[k];
                        for (int i = 1; i < k; i++) begin
                            dly_q[i] <= dly_q[i-1];
                        end
                    end
                end

                assign row_beat[k] = dly_q[k-1];
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/spike_mac_pe.sv */
`default_nettype none

module spike_mac_pe (
    input  logic                                         s_clk,
    input  logic                                         s_rst,
    input  logic                                         we,
    input  systolic_pkg::bank_e                          wr_bank,
    input  logic signed [systolic_pkg::WEIGHT_WIDTH-1:0] wr_value,
    input  systolic_pkg::spike_beat_t                    beat,
    input  systolic_pkg::psum_beat_t                     psum_in,
    output systolic_pkg::psum_beat_t                     psum_out
);
    import systolic_pkg::*;

    // count * weight needs two extra bits, range -384..381
    localparam int PROD_WIDTH = WEIGHT_WIDTH + 2;

    logic signed [WEIGHT_WIDTH-1:0]        weight_b0;
    logic signed [WEIGHT_WIDTH-1:0]        weight_b1;
    logic signed [WEIGHT_WIDTH-1:0]        calc_weight;
    logic signed [PROD_WIDTH-1:0]          weight_x1;
    logic signed [PROD_WIDTH-1:0]          weight_x2;
    logic signed [PROD_WIDTH-1:0]          weight_x3;
    logic signed [PROD_WIDTH-1:0]          prod_q [TIME_STEPS];
    logic                                  prod_valid;
    logic [TIME_STEPS-1:0][LANE_WIDTH-1:0] lane_sum;
    logic [TIME_STEPS-1:0][LANE_WIDTH-1:0] out_lanes;
    logic                                  out_valid;

    // ping-pong weights, one bank loads while the other computes
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            weight_b0 <= '0;
            weight_b1 <= '0;
        end else if (we) begin
            if (wr_bank == BANK1) begin
                weight_b1 <= wr_value;
            end else begin
                weight_b0 <= wr_value;
            end
        end
    end

    assign calc_weight = (beat.bank == BANK1) ? weight_b1 : weight_b0;

    // shift-and-add multiples of the weight
    assign weight_x1 = PROD_WIDTH'(calc_weight);
    assign weight_x2 = weight_x1 <<< 1;
    assign weight_x3 = weight_x2 + weight_x1;

    // stage 1: select the multiple per time step
    always_ff @(posedge s_clk) begin
        if (beat.valid) begin
            for (int t = 0; t < TIME_STEPS; t++) begin
                case (beat.spikes[t])
                    2'd0:    prod_q[t] <= '0;
                    2'd1:    prod_q[t] <= weight_x1;
                    2'd2:    prod_q[t] <= weight_x2;
                    default: prod_q[t] <= weight_x3;
                endcase
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= beat.valid;
        end
    end

    // lane adders, each wraps at LANE_WIDTH
    always_comb begin
        for (int t = 0; t < TIME_STEPS; t++) begin
            lane_sum[t] = $signed(psum_in.lanes[t]) + LANE_WIDTH'(prod_q[t]);
        end
    end

    // stage 2: psum_in from the row above arrives in this cycle
    always_ff @(posedge s_clk) begin
        if (prod_valid) begin
            out_lanes <= lane_sum;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prod_valid;
        end
    end

    assign psum_out.valid = out_valid;
    assign psum_out.lanes = out_lanes;

endmodule

`default_nettype wire

/* rtl/psum_accumulator.sv */
`default_nettype none

module psum_accumulator #(
    parameter int ACC_WIDTH = 24
) (
    input  logic                                           s_clk,
    input  logic                                           s_rst,
    input  systolic_pkg::psum_beat_t                       col_out,
    input  logic                                           pass_first,
    input  logic                                           pass_last,
    output logic                                           result_valid,
    output logic [systolic_pkg::TIME_STEPS-1:0][ACC_WIDTH-1:0] result
);
    import systolic_pkg::*;

    accum_state_e                         state;
    logic                                 accept;
    logic [TIME_STEPS-1:0][ACC_WIDTH-1:0] lane_ext;
    logic [TIME_STEPS-1:0][ACC_WIDTH-1:0] sum_next;
    logic [TIME_STEPS-1:0][ACC_WIDTH-1:0] acc_q;

    // idle beats without a first marker are dropped
    assign accept = col_out.valid && (pass_first || (state == ACC_RUN));

    // first marker restarts the sum, otherwise keep adding
    always_comb begin
        for (int t = 0; t < TIME_STEPS; t++) begin
            lane_ext[t] = ACC_WIDTH'($signed(col_out.lanes[t]));
            sum_next[t] = pass_first ? lane_ext[t] : acc_q[t] + lane_ext[t];
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state        <= ACC_IDLE;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (accept) begin
                if (pass_last) begin
                    // also covers a one-vector pass
                    state        <= ACC_IDLE;
                    result_valid <= 1'b1;
                end else begin
                    state <= ACC_RUN;
                end
            end
        end
    end

    // running sums
    always_ff @(posedge s_clk) begin
        if (accept) begin
            acc_q <= sum_next;
        end
    end

    // result holds until the next pass completes
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            result <= '0;
        end else if (accept && pass_last) begin
            result <= sum_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/spike_column_top.sv */
`default_nettype none

module spike_column_top #(
    parameter int NUM_ROWS  = 8,
    parameter int ACC_WIDTH = 24
) (
    input  logic                                          s_clk,
    input  logic                                          s_rst,
    input  systolic_pkg::weight_wr_t                      wr,
    input  logic                                          act_valid,
    input  systolic_pkg::bank_e                           act_bank,
    input  logic                                          act_first,
    input  logic                                          act_last,
    input  logic [NUM_ROWS-1:0]
                 [systolic_pkg::TIME_STEPS*systolic_pkg::SPIKE_WIDTH-1:0] act_spikes,
    output logic                                          result_valid,
    output logic [systolic_pkg::TIME_STEPS-1:0][ACC_WIDTH-1:0] result
);
    import systolic_pkg::*;

    logic [NUM_ROWS-1:0]            row_we;
    bank_e                          wr_bank;
    logic signed [WEIGHT_WIDTH-1:0] wr_value;
    spike_beat_t [NUM_ROWS-1:0]     row_beat;
    psum_beat_t [NUM_ROWS:0]        psum_chain;
    logic                           pass_first;
    logic                           pass_last;

    weight_loader #(
        .NUM_ROWS (NUM_ROWS)
    ) u_loader (
        .s_clk    (s_clk),
        .s_rst    (s_rst),
        .wr       (wr),
        .row_we   (row_we),
        .wr_bank  (wr_bank),
        .wr_value (wr_value)
    );

    spike_skew_feeder #(
        .NUM_ROWS (NUM_ROWS)
    ) u_feeder (
        .s_clk      (s_clk),
        .s_rst      (s_rst),
        .act_valid  (act_valid),
        .act_bank   (act_bank),
        .act_first  (act_first),
        .act_last   (act_last),
        .act_spikes (act_spikes),
        .row_beat   (row_beat),
        .pass_first (pass_first),
        .pass_last  (pass_last)
    );

    // top of the column starts from zero
    assign psum_chain[0] = '0;

    genvar k;
    generate
        for (k = 0; k < NUM_ROWS; k++) begin : g_pe
            spike_mac_pe u_pe (
                .s_clk    (s_clk),
                .s_rst    (s_rst),
                .we       (row_we[k]),
                .wr_bank  (wr_bank),
                .wr_value (wr_value),
                .beat     (row_beat[k]),
                .psum_in  (psum_chain[k]),
                .psum_out (psum_chain[k+1])
            );
        end
    endgenerate

    psum_accumulator #(
        .ACC_WIDTH (ACC_WIDTH)
    ) u_accum (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .col_out      (psum_chain[NUM_ROWS]),
        .pass_first   (pass_first),
        .pass_last    (pass_last),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

/* testbench/column_model.svh */
`ifndef COLUMN_MODEL_SVH
`define COLUMN_MODEL_SVH

// weight mirror, indexed [bank][row]
int model_weight [2][NUM_ROWS];

// running per-lane sums of the pass in progress
logic [TIME_STEPS-1:0][ACC_WIDTH-1:0] model_acc;

function automatic void clear_banks();
    for (int b = 0; b < 2; b++) begin
        for (int k = 0; k < NUM_ROWS; k++) begin
            model_weight[b][k] = 0;
        end
    end
    model_acc = '0;
endfunction

// rows outside the column have no PE to store into
function automatic void mirror_write(input int bank, input int row, input int value);
    if (row < NUM_ROWS) begin
        model_weight[bank][row] = value;
    end
endfunction

function automatic void add_vector(input int bank,
                                   input logic [NUM_ROWS-1:0][TIME_STEPS*SPIKE_WIDTH-1:0] spikes,
                                   input bit first);
    int                    lane;
    logic [LANE_WIDTH-1:0] lane_w;
    for (int t = 0; t < TIME_STEPS; t++) begin
        lane = 0;
        for (int k = 0; k < NUM_ROWS; k++) begin
            lane += int'(spikes[k][SPIKE_WIDTH*t +: SPIKE_WIDTH]) * model_weight[bank][k];
        end
        // column lanes wrap at 16 bits, then sign-extend into the accumulator
        lane_w = LANE_WIDTH'(lane);
        lane = int'($signed(lane_w));
        if (first) begin
            model_acc[t] = ACC_WIDTH'(lane);
        end else begin
            model_acc[t] = model_acc[t] + ACC_WIDTH'(lane);
        end
    end
endfunction

`endif

/* testbench/tb_spike_column.sv */
`default_nettype none

module tb_spike_column;
    timeunit 1ns;
    timeprecision 1ps;

    import systolic_pkg::*;

    localparam int NUM_ROWS   = 8;
    localparam int ACC_WIDTH  = 24;
    localparam int GRP_WIDTH  = TIME_STEPS * SPIKE_WIDTH;
    // drive edge to the edge that raises result_valid
    localparam int LATENCY    = NUM_ROWS + 3;
    localparam int DRAIN_WAIT = 4 * LATENCY;

    logic                                 s_clk;
    logic                                 s_rst;
    weight_wr_t                           wr;
    logic                                 act_valid;
    bank_e                                act_bank;
    logic                                 act_first;
    logic                                 act_last;
    logic [NUM_ROWS-1:0][GRP_WIDTH-1:0]   act_spikes;
    logic                                 result_valid;
    logic [TIME_STEPS-1:0][ACC_WIDTH-1:0] result;

    int                              cycle = 0;
    string                           test_name = "reset";
    logic [TIME_STEPS*ACC_WIDTH-1:0] exp_result_q [$];
    int                              exp_cycle_q [$];

    `include "column_model.svh"

    spike_column_top #(
        .NUM_ROWS  (NUM_ROWS),
        .ACC_WIDTH (ACC_WIDTH)
    ) u_dut (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .wr           (wr),
        .act_valid    (act_valid),
        .act_bank     (act_bank),
        .act_first    (act_first),
        .act_last     (act_last),
        .act_spikes   (act_spikes),
        .result_valid (result_valid),
        .result       (result)
    );

    initial s_clk = 1'b0;
    always #10 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
            fail_run("a checked value did not match");
        end
    endtask

    // outputs compared on the falling edge
    always @(negedge s_clk) begin
        if (!s_rst && result_valid) begin
            if (exp_result_q.size() == 0) begin
                fail_run("result_valid pulsed with no pass outstanding");
            end else begin
                check({test_name, " latency"}, 128'(exp_cycle_q.pop_front()), 128'(cycle));
                check({test_name, " result"}, 128'(exp_result_q.pop_front()), 128'(result));
            end
        end
    end

    function automatic logic [NUM_ROWS-1:0][GRP_WIDTH-1:0] rand_spikes();
        logic [NUM_ROWS-1:0][GRP_WIDTH-1:0] v;
        for (int k = 0; k < NUM_ROWS; k++) begin
            v[k] = GRP_WIDTH'($urandom());
        end
        return v;
    endfunction

    function automatic int rand_weight();
        logic signed [WEIGHT_WIDTH-1:0] w;
        w = WEIGHT_WIDTH'($urandom());
        return int'(w);
    endfunction

    // inputs change 2 ns after the edge and fall back to idle
    task automatic advance_cycle();
        @(posedge s_clk);
        #2;
        wr = '0;
        act_valid = 1'b0;
        act_first = 1'b0;
        act_last = 1'b0;
    endtask

    task automatic set_write(input bank_e bank, input int row, input int value);
        wr.valid = 1'b1;
        wr.bank = bank;
        wr.row = ROW_IDX_WIDTH'(row);
        wr.value = WEIGHT_WIDTH'(value);
        mirror_write(int'(bank), row, value);
    endtask

    task automatic set_vector(input bank_e bank, input bit first, input bit last,
                              input logic [NUM_ROWS-1:0][GRP_WIDTH-1:0] spikes);
        act_valid = 1'b1;
        act_bank = bank;
        act_first = first;
        act_last = last;
        act_spikes = spikes;
        add_vector(int'(bank), spikes, first);
        if (last) begin
            exp_result_q.push_back(model_acc);
            exp_cycle_q.push_back(cycle + LATENCY);
        end
    endtask

    task automatic load_bank(input bank_e bank, input bit use_random, input int fixed);
        for (int r = 0; r < NUM_ROWS; r++) begin
            set_write(bank, r, use_random ? rand_weight() : fixed);
            advance_cycle();
        end
        // let the last write land before any vector reads it
        advance_cycle();
        advance_cycle();
    endtask

    task automatic run_pass(input bank_e bank, input int len, input bit saturate);
        logic [NUM_ROWS-1:0][GRP_WIDTH-1:0] spk;
        for (int i = 0; i < len; i++) begin
            if (saturate) begin
                spk = '1;
            end else begin
                spk = rand_spikes();
            end
            set_vector(bank, i == 0, i == len - 1, spk);
            advance_cycle();
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_result_q.size() != 0 && waited < DRAIN_WAIT) begin
            advance_cycle();
            waited++;
        end
        if (exp_result_q.size() != 0) begin
            fail_run("timed out waiting for pass results");
        end
    endtask

    initial begin
        void'($urandom(18377));
        s_rst = 1'b1;
        wr = '0;
        act_valid = 1'b0;
        act_bank = BANK0;
        act_first = 1'b0;
        act_last = 1'b0;
        act_spikes = '0;
        clear_banks();
        repeat (8) @(posedge s_clk);
        #2;
        s_rst = 1'b0;
        check(test_name, '0, 128'(result));

        // vectors without a first marker are dropped while idle, last marker or not
        test_name = "unmarked";
        for (int i = 0; i < 30; i++) begin
            act_valid = 1'b1;
            act_bank = bank_e'($urandom_range(1));
            act_last = 1'($urandom_range(1));
            act_spikes = rand_spikes();
            advance_cycle();
        end
        test_name = "zero weights";
        for (int i = 0; i < 5; i++) begin
            run_pass(bank_e'($urandom_range(1)), $urandom_range(4, 1), 1'b0);
        end
        wait_drain();

        test_name = "single vector";
        load_bank(BANK0, 1'b1, 0);
        for (int i = 0; i < 20; i++) begin
            run_pass(BANK0, 1, 1'b0);
            if ($urandom_range(1) == 1) begin
                advance_cycle();
            end
        end
        wait_drain();

        test_name = "multi vector";
        for (int i = 0; i < 10; i++) begin
            run_pass(BANK0, $urandom_range(6, 2), 1'b0);
        end
        wait_drain();

        // BANK1 fills while a pass computes on BANK0
        test_name = "ping pong";
        for (int r = 0; r < NUM_ROWS; r++) begin
            set_write(BANK1, r, rand_weight());
            set_vector(BANK0, r == 0, r == NUM_ROWS - 1, rand_spikes());
            advance_cycle();
        end
        advance_cycle();
        advance_cycle();
        for (int i = 0; i < 12; i++) begin
            run_pass((i % 2 == 1) ? BANK1 : BANK0, $urandom_range(4, 1), 1'b0);
        end
        wait_drain();

        // 3000 vectors of +3048 or -3072 run past the 24-bit range
        test_name = "extreme";
        load_bank(BANK0, 1'b0, 127);
        load_bank(BANK1, 1'b0, -128);
        run_pass(BANK0, 1, 1'b1);
        run_pass(BANK1, 1, 1'b1);
        run_pass(BANK0, 3000, 1'b1);
        run_pass(BANK1, 3000, 1'b1);
        wait_drain();

        test_name = "row out of range";
        load_bank(BANK0, 1'b1, 0);
        for (int r = NUM_ROWS; r < (1 << ROW_IDX_WIDTH); r++) begin
            set_write(bank_e'(r % 2), r, rand_weight());
            advance_cycle();
        end
        advance_cycle();
        advance_cycle();
        for (int i = 0; i < 8; i++) begin
            run_pass(bank_e'($urandom_range(1)), $urandom_range(3, 1), 1'b0);
        end
        wait_drain();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* spike_column.f */
+incdir+testbench
rtl/systolic_pkg.sv
rtl/weight_loader.sv
rtl/spike_skew_feeder.sv
rtl/spike_mac_pe.sv
rtl/psum_accumulator.sv
rtl/spike_column_top.sv
testbench/tb_spike_column.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the spike column testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_spike_column \
    -f spike_column.f -o tb_spike_column > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_spike_column > sim.log 2>&1 || true
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
